//--- cpu_top.f
hdl/cpu_isa_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/cpu_regfile.sv
hdl/cpu_control.sv
hdl/cpu_datapath.sv
hdl/cpu_top.sv
verif/cpu_tb.sv

//--- hdl/cpu_control.sv
`timescale 1ns/1ps

module cpu_control
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset,
  input  cpu_word_t i_ir,
  input  logic      i_alu_n,
  input  logic      i_alu_z,
  output cpu_ctrl_t o_ctrl
);

  typedef enum logic [1:0] {
    S_START,
    S_EXECUTE,
    S_MEM_LD,
    S_MEM_ST
  } state_e;

  state_e      state;
  state_e      next_state;
  cpu_opcode_e opcode;
  logic        imm;

  assign opcode = ir_opcode(i_ir);
  assign imm    = ir_is_imm(i_ir);

  // fetch the word after the current one and advance pc
  function automatic cpu_ctrl_t seq_fetch(cpu_ctrl_t c);
    cpu_ctrl_t r;
    r          = c;
    r.mem_rd   = 1'b1;
    r.addr_sel = ADDR_PC_INC;
    r.pc_sel   = PC_INC;
    r.pc_ld    = 1'b1;
    return r;
  endfunction

  // fetch from the jump target, register or pc relative
  function automatic cpu_ctrl_t jump_fetch(cpu_ctrl_t c, logic is_imm);
    cpu_ctrl_t r;
    r        = c;
    r.mem_rd = 1'b1;
    r.pc_ld  = 1'b1;
    if (is_imm) begin
      r.addr_sel = ADDR_PC_REL;
      r.pc_sel   = PC_REL;
    end else begin
      r.addr_sel = ADDR_RX;
      r.pc_sel   = PC_RX;
    end
    return r;
  endfunction

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      state <= S_START;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    o_ctrl     = CPU_CTRL_IDLE;

    case (state)
      S_START: begin
        // first fetch from pc zero once out of reset
        if (!i_reset) begin
          o_ctrl.mem_rd   = 1'b1;
          o_ctrl.addr_sel = ADDR_PC;
          next_state      = S_EXECUTE;
        end
      end

      S_EXECUTE: begin
        // keep a copy, ld needs its rx during write-back
        o_ctrl.ir_ld      = 1'b1;
        o_ctrl.b_from_reg = !imm;

        case (opcode)
          OP_MV: begin
            o_ctrl          = seq_fetch(o_ctrl);
            o_ctrl.rf_write = 1'b1;
            if (imm) begin
              o_ctrl.wb_sel = WB_IMM;
            end else begin
              o_ctrl.wb_sel = WB_RY;
            end
          end
          OP_ADD, OP_SUB: begin
            o_ctrl          = seq_fetch(o_ctrl);
            o_ctrl.rf_write = 1'b1;
            o_ctrl.wb_sel   = WB_ALU;
            o_ctrl.n_ld     = 1'b1;
            o_ctrl.z_ld     = 1'b1;
            o_ctrl.alu_op   = (opcode == OP_SUB) ? ALU_SUB : ALU_ADD;
          end
          OP_CMP: begin
            // flags only, no write-back
            o_ctrl        = seq_fetch(o_ctrl);
            o_ctrl.n_ld   = 1'b1;
            o_ctrl.z_ld   = 1'b1;
            o_ctrl.alu_op = ALU_SUB;
          end
          OP_LD: begin
            o_ctrl.mem_rd   = 1'b1;
            o_ctrl.addr_sel = ADDR_RY;
            next_state      = S_MEM_LD;
          end
          OP_ST: begin
            o_ctrl.mem_wr   = 1'b1;
            o_ctrl.addr_sel = ADDR_RY;
            next_state      = S_MEM_ST;
          end
          OP_MVHI: begin
            o_ctrl          = seq_fetch(o_ctrl);
            o_ctrl.rf_write = 1'b1;
            o_ctrl.wb_sel   = WB_HI;
          end
          OP_JUMP: begin
            o_ctrl = jump_fetch(o_ctrl, imm);
          end
          OP_JZ: begin
            if (i_alu_z) begin
              o_ctrl = jump_fetch(o_ctrl, imm);
            end else begin
              o_ctrl = seq_fetch(o_ctrl);
            end
          end
          OP_JN: begin
            if (i_alu_n) begin
              o_ctrl = jump_fetch(o_ctrl, imm);
            end else begin
              o_ctrl = seq_fetch(o_ctrl);
            end
          end
          OP_CALL: begin
            o_ctrl          = jump_fetch(o_ctrl, imm);
            o_ctrl.rf_write = 1'b1;
            o_ctrl.wr_link  = 1'b1;
            o_ctrl.wb_sel   = WB_PC_INC;
          end
          // unknown opcode behaves as a no-op
          default: begin
            o_ctrl = seq_fetch(o_ctrl);
          end
        endcase
      end

      S_MEM_LD: begin
        o_ctrl          = seq_fetch(o_ctrl);
        o_ctrl.rf_write = 1'b1;
        o_ctrl.wb_sel   = WB_MEM;
        next_state      = S_EXECUTE;
      end

      S_MEM_ST: begin
        o_ctrl     = seq_fetch(o_ctrl);
        next_state = S_EXECUTE;
      end

      default: begin
        next_state = S_START;
      end
    endcase
  end

  a_no_rd_wr_overlap: assert property (
    @(posedge i_clk) disable iff (i_reset) !(o_ctrl.mem_rd && o_ctrl.mem_wr)
  );

endmodule

//--- hdl/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

  // memory address source
  typedef enum logic [2:0] {
    ADDR_PC     = 3'd0,
    ADDR_PC_INC = 3'd1,
    ADDR_RX     = 3'd2,
    ADDR_RY     = 3'd3,
    ADDR_PC_REL = 3'd4
  } addr_sel_e;

  // next pc source, code 3 unused
  typedef enum logic [1:0] {
    PC_RX  = 2'd0,
    PC_INC = 2'd1,
    PC_REL = 2'd2
  } pc_sel_e;

  // register write-back source
  typedef enum logic [2:0] {
    WB_IMM    = 3'd0,
    WB_HI     = 3'd1,
    WB_ALU    = 3'd2,
    WB_PC_INC = 3'd3,
    WB_MEM    = 3'd4,
    WB_RY     = 3'd6
  } wb_sel_e;

  typedef enum logic {
    ALU_ADD = 1'b0,
    ALU_SUB = 1'b1
  } alu_op_e;

  typedef struct packed {
    logic      mem_rd;
    logic      mem_wr;
    addr_sel_e addr_sel;
    pc_sel_e   pc_sel;
    logic      pc_ld;
    logic      ir_ld;
    wb_sel_e   wb_sel;
    logic      rf_write;
    logic      wr_link;
    logic      n_ld;
    logic      z_ld;
    logic      b_from_reg;
    alu_op_e   alu_op;
  } cpu_ctrl_t;

  localparam cpu_ctrl_t CPU_CTRL_IDLE = '0;

endpackage

//--- hdl/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset,
  input  cpu_ctrl_t i_ctrl,
  input  cpu_word_t i_mem_rdata,
  output cpu_word_t o_mem_addr,
  output cpu_word_t o_mem_wdata,
  output logic      o_alu_n,
  output logic      o_alu_z
);

  cpu_word_t    pc;
  cpu_word_t    ir_hold;
  cpu_word_t    instr;
  cpu_word_t    rx_val;
  cpu_word_t    ry_val;
  cpu_word_t    imm_sext;
  cpu_word_t    pc_inc;
  cpu_word_t    pc_rel;
  cpu_word_t    pc_next;
  cpu_word_t    alu_b;
  cpu_word_t    alu_res;
  cpu_word_t    wb_data;
  cpu_imm8_t    imm8;
  cpu_reg_idx_t wr_idx;

  // bus carries load data during ld write-back, use held copy then
  assign instr = (i_ctrl.wb_sel == WB_MEM) ? ir_hold : i_mem_rdata;

  assign imm8     = ir_imm8(instr);
  assign imm_sext = {{8{imm8[7]}}, imm8};
  assign pc_inc   = pc + 16'd1;
  assign pc_rel   = pc + imm_sext;
  assign wr_idx   = i_ctrl.wr_link ? CPU_LINK_REG : ir_rx(instr);

  cpu_regfile i_regfile (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_rd_a_idx (ir_rx(instr)),
    .i_rd_b_idx (ir_ry(instr)),
    .i_wr_idx   (wr_idx),
    .i_wr_en    (i_ctrl.rf_write),
    .i_wr_data  (wb_data),
    .o_rd_a     (rx_val),
    .o_rd_b     (ry_val)
  );

  assign alu_b   = i_ctrl.b_from_reg ? ry_val : imm_sext;
  assign alu_res = (i_ctrl.alu_op == ALU_SUB) ? rx_val - alu_b : rx_val + alu_b;

  always_comb begin
    case (i_ctrl.addr_sel)
      ADDR_PC_INC: o_mem_addr = pc_inc;
      ADDR_RX:     o_mem_addr = rx_val;
      ADDR_RY:     o_mem_addr = ry_val;
      ADDR_PC_REL: o_mem_addr = pc_rel;
      default:     o_mem_addr = pc;
    endcase
  end

  always_comb begin
    case (i_ctrl.pc_sel)
      PC_RX:   pc_next = rx_val;
      PC_REL:  pc_next = pc_rel;
      default: pc_next = pc_inc;
    endcase
  end

  always_comb begin
    case (i_ctrl.wb_sel)
      WB_HI:     wb_data = {imm8, rx_val[7:0]};
      WB_ALU:    wb_data = alu_res;
      WB_PC_INC: wb_data = pc_inc;
      WB_MEM:    wb_data = i_mem_rdata;
      WB_RY:     wb_data = ry_val;
      default:   wb_data = imm_sext;
    endcase
  end

  assign o_mem_wdata = rx_val;

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      pc      <= '0;
      o_alu_n <= 1'b0;
      o_alu_z <= 1'b0;
    end else begin
      if (i_ctrl.pc_ld) begin
        pc <= pc_next;
      end
      if (i_ctrl.n_ld) begin
        o_alu_n <= alu_res[15];
      end
      if (i_ctrl.z_ld) begin
        o_alu_z <= (alu_res == '0);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ctrl.ir_ld) begin
      ir_hold <= i_mem_rdata;
    end
  end

  a_pc_sel_valid: assert property (
    @(posedge i_clk) disable iff (i_reset) i_ctrl.pc_sel inside {PC_RX, PC_INC, PC_REL}
  );

endmodule

//--- hdl/cpu_isa_pkg.sv
package cpu_isa_pkg;

  typedef logic [15:0] cpu_word_t;
  typedef logic [2:0]  cpu_reg_idx_t;
  typedef logic [7:0]  cpu_imm8_t;

  localparam int CPU_NUM_REGS = 8;

  // opcode lives in bits 3:0
  typedef enum logic [3:0] {
    OP_MV   = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_CMP  = 4'd3,
    OP_LD   = 4'd4,
    OP_ST   = 4'd5,
    OP_MVHI = 4'd6,
    OP_JUMP = 4'd8,
    OP_JZ   = 4'd9,
    OP_JN   = 4'd10,
    OP_CALL = 4'd12
  } cpu_opcode_e;

  localparam int IMM_FLAG_BIT = 4;
  localparam int RX_LSB       = 5;
  localparam int RY_LSB       = 8;
  localparam int IMM8_LSB     = 8;

  // r7 receives the return address of call
  localparam cpu_reg_idx_t CPU_LINK_REG = 3'd7;

  function automatic cpu_opcode_e ir_opcode(cpu_word_t w);
    return cpu_opcode_e'(w[3:0]);
  endfunction

  function automatic logic ir_is_imm(cpu_word_t w);
    return w[IMM_FLAG_BIT];
  endfunction

  function automatic cpu_reg_idx_t ir_rx(cpu_word_t w);
    return w[RX_LSB +: $bits(cpu_reg_idx_t)];
  endfunction

  function automatic cpu_reg_idx_t ir_ry(cpu_word_t w);
    return w[RY_LSB +: $bits(cpu_reg_idx_t)];
  endfunction

  function automatic cpu_imm8_t ir_imm8(cpu_word_t w);
    return w[IMM8_LSB +: $bits(cpu_imm8_t)];
  endfunction

endpackage

//--- hdl/cpu_regfile.sv
`timescale 1ns/1ps

module cpu_regfile
  import cpu_isa_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_reset,
  input  cpu_reg_idx_t i_rd_a_idx,
  input  cpu_reg_idx_t i_rd_b_idx,
  input  cpu_reg_idx_t i_wr_idx,
  input  logic         i_wr_en,
  input  cpu_word_t    i_wr_data,
  output cpu_word_t    o_rd_a,
  output cpu_word_t    o_rd_b
);

  cpu_word_t regs [CPU_NUM_REGS];

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      for (int i = 0; i < CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr_en) begin
      regs[i_wr_idx] <= i_wr_data;
    end
  end

  // read ports are combinational
  assign o_rd_a = regs[i_rd_a_idx];
  assign o_rd_b = regs[i_rd_b_idx];

  a_wr_idx_known: assert property (
    @(posedge i_clk) disable iff (i_reset) i_wr_en |-> !$isunknown(i_wr_idx)
  );

endmodule

//--- hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset,
  input  cpu_word_t i_mem_rdata,
  output logic      o_mem_rd,
  output logic      o_mem_wr,
  output cpu_word_t o_mem_addr,
  output cpu_word_t o_mem_wdata
);

  cpu_ctrl_t ctrl;
  logic      alu_n;
  logic      alu_z;

  // instruction decode reads the bus word directly
  cpu_control i_control (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_ir    (i_mem_rdata),
    .i_alu_n (alu_n),
    .i_alu_z (alu_z),
    .o_ctrl  (ctrl)
  );

  cpu_datapath i_datapath (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_ctrl      (ctrl),
    .i_mem_rdata (i_mem_rdata),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .o_alu_n     (alu_n),
    .o_alu_z     (alu_z)
  );

  assign o_mem_rd = ctrl.mem_rd;
  assign o_mem_wr = ctrl.mem_wr;

endmodule

//--- verif/cpu_stim.mem
// words 0 to 63: program image, eight words per line
// from word 64: store count, then one address and data pair per line
@0
40D0 8530 0625 01D1 0140 1246 0645 01D1
7F70 0261 0665 01D1 0390 0382 0685 01D1
8092 9091 0685 01D1 0483 0319 11B0 06A5
22B0 06A5 01D1 0573 031A 0219 0665 01D1
0323 021A 0625 33B0 06A5 01D1 4310 0044
0645 01D1 2D10 0008 0625 0218 0625 041C
0625 0625 0625 06E5 01D1 3910 000C 0625
0625 06E5 0018 0000 0000 0000 0000 0000
@40
000B
0040 FF85
0041 1285
0042 1304
0043 ECFF
0044 ED0F
0045 0022
0046 1304
0047 0033
0048 ECFF
0049 0030
004A 0037

//--- verif/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb
  import cpu_isa_pkg::*;
();

  localparam int PROG_WORDS     = 64;
  localparam int STIM_WORDS     = 128;
  localparam int MEM_WORDS      = 256;
  localparam int EXP_BASE       = 64;
  localparam int TIMEOUT_CYCLES = 8 * PROG_WORDS + 64;

  logic      i_clk;
  logic      i_reset;
  cpu_word_t i_mem_rdata;
  logic      o_mem_rd;
  logic      o_mem_wr;
  cpu_word_t o_mem_addr;
  cpu_word_t o_mem_wdata;

  cpu_word_t stim [STIM_WORDS];
  cpu_word_t mem  [MEM_WORDS];
  logic      rd_pending;
  cpu_word_t rd_addr;
  cpu_word_t exp_addr;
  cpu_word_t exp_data;
  logic      seen_first_read;
  int        exp_count;
  int        store_idx;
  int        errors;
  int        cycles;

  cpu_top i_dut (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_mem_rdata (i_mem_rdata),
    .o_mem_rd    (o_mem_rd),
    .o_mem_wr    (o_mem_wr),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata)
  );

  always #4 i_clk = ~i_clk;

  // read data shows up on the falling edge after the read
  always @(posedge i_clk) begin
    rd_pending <= o_mem_rd;
    rd_addr    <= o_mem_addr;
    if (o_mem_wr) begin
      mem[o_mem_addr[7:0]] <= o_mem_wdata;
    end
  end

  always @(negedge i_clk) begin
    if (rd_pending) begin
      i_mem_rdata <= mem[rd_addr[7:0]];
    end
  end

  // bus checks at the rising edge
  always @(posedge i_clk) begin
    if (i_reset) begin
      if (o_mem_rd !== 1'b0) begin
        errors++;
        $display("FAIL o_mem_rd: got %h, expected %h during reset", o_mem_rd, 1'b0);
      end
      if (o_mem_wr !== 1'b0) begin
        errors++;
        $display("FAIL o_mem_wr: got %h, expected %h during reset", o_mem_wr, 1'b0);
      end
    end else begin
      if (o_mem_rd && !seen_first_read) begin
        seen_first_read = 1'b1;
        if (o_mem_addr !== 16'h0000) begin
          errors++;
          $display("FAIL o_mem_addr: got %h, expected %h on first fetch", o_mem_addr, 16'h0000);
        end
      end
      if (o_mem_wr) begin
        if (store_idx >= exp_count) begin
          errors++;
          $display("store to address %h beyond the expected list", o_mem_addr);
        end else begin
          exp_addr = stim[EXP_BASE + 1 + 2 * store_idx];
          exp_data = stim[EXP_BASE + 2 + 2 * store_idx];
          if (o_mem_addr !== exp_addr) begin
            errors++;
            $display("FAIL o_mem_addr: got %h, expected %h", o_mem_addr, exp_addr);
          end
          if (o_mem_wdata !== exp_data) begin
            errors++;
            $display("FAIL o_mem_wdata: got %h, expected %h", o_mem_wdata, exp_data);
          end
          store_idx++;
        end
      end
    end
  end

  initial begin
    i_clk           = 1'b0;
    i_reset         = 1'b1;
    i_mem_rdata     = '0;
    rd_pending      = 1'b0;
    rd_addr         = '0;
    seen_first_read = 1'b0;
    errors          = 0;
    store_idx       = 0;
    cycles          = 0;
    exp_count       = 0;

    $readmemh("verif/cpu_stim.mem", stim);
    // fill pattern first and the program over the low words
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = {~a[7:0], a[7:0]};
    end
    for (int a = 0; a < PROG_WORDS; a++) begin
      mem[a] = stim[a];
    end
    if ($isunknown(stim[EXP_BASE])) begin
      errors++;
      $display("store list missing from the stimulus file");
    end else begin
      exp_count = stim[EXP_BASE];
    end

    repeat (8) @(negedge i_clk);
    i_reset = 1'b0;

    while (store_idx < exp_count && cycles < TIMEOUT_CYCLES) begin
      @(negedge i_clk);
      cycles++;
    end
    if (store_idx < exp_count) begin
      errors++;
      $display("timeout after %0d cycles with stores still missing", cycles);
    end else begin
      // late stores from the self-jump loop count as extra
      repeat (16) @(negedge i_clk);
    end

    $display("errors: %0d, stores checked: %0d of %0d", errors, store_idx, exp_count);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
